// File: include/rv_exec_defines.svh
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Integer register width.
`define RV_XLEN 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply/divide engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RV_MD_STEPS `RV_XLEN  // One operand bit per cycle.

`endif

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_isa_pkg::alu_sel_t  i_alu_sel,
    input  wire rv_isa_pkg::br_sel_t   i_br_sel,
    input  wire rv_isa_pkg::sign_sel_t i_sign_sel,
    input  wire rv_isa_pkg::uintx_t    i_op1,
    input  wire rv_isa_pkg::uintx_t    i_op2,
    output rv_isa_pkg::uintx_t         o_result,
    output logic                       o_branch_take
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;
    logic       br_signed;
    logic       br_lt;

    assign shamt = i_op2[4:0];
    assign eq    = (i_op1 == i_op2);
    assign lt_s  = ($signed(i_op1) < $signed(i_op2));
    assign lt_u  = (i_op1 < i_op2);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Integer operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (i_alu_sel)
            rv_isa_pkg::ALU_ADD:   o_result = i_op1 + i_op2;
            rv_isa_pkg::ALU_SUB:   o_result = i_op1 - i_op2;
            rv_isa_pkg::ALU_AND:   o_result = i_op1 & i_op2;
            rv_isa_pkg::ALU_OR:    o_result = i_op1 | i_op2;
            rv_isa_pkg::ALU_XOR:   o_result = i_op1 ^ i_op2;
            rv_isa_pkg::ALU_SLL:   o_result = i_op1 << shamt;
            rv_isa_pkg::ALU_SRL:   o_result = i_op1 >> shamt;
            rv_isa_pkg::ALU_SRA:   o_result = rv_isa_pkg::uintx_t'($signed(i_op1) >>> shamt);
            rv_isa_pkg::ALU_SLT:   o_result = rv_isa_pkg::uintx_t'(lt_s);
            rv_isa_pkg::ALU_SLTU:  o_result = rv_isa_pkg::uintx_t'(lt_u);
            rv_isa_pkg::ALU_COPY1: o_result = i_op1;
            default:               o_result = '0;  // Mul/div come from the engine.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch condition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (i_br_sel)
            rv_isa_pkg::BR_BLT,
            rv_isa_pkg::BR_BGE:  br_signed = 1'b1;
            rv_isa_pkg::BR_BLTU,
            rv_isa_pkg::BR_BGEU: br_signed = 1'b0;
            default:             br_signed = (i_sign_sel == rv_isa_pkg::OP_SIGNED);
        endcase
    end

    assign br_lt = br_signed ? lt_s : lt_u;

    always_comb begin
        case (i_br_sel)
            rv_isa_pkg::BR_BEQ:  o_branch_take = eq;
            rv_isa_pkg::BR_BNE:  o_branch_take = !eq;
            rv_isa_pkg::BR_BLT,
            rv_isa_pkg::BR_BLTU: o_branch_take = br_lt;
            rv_isa_pkg::BR_BGE,
            rv_isa_pkg::BR_BGEU: o_branch_take = !br_lt;
            default:             o_branch_take = 1'b0;  // Not a branch.
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                        clk,
    input  wire                        i_arst_n,
    input  wire                        i_flush,
    input  wire                        i_valid,
    input  wire                        i_is_new,
    input  wire rv_isa_pkg::addr_t     i_pc,
    input  wire rv_isa_pkg::alu_sel_t  i_alu_sel,
    input  wire rv_isa_pkg::br_sel_t   i_br_sel,
    input  wire rv_isa_pkg::sign_sel_t i_sign_sel,
    input  wire                        i_jmp_pc,
    input  wire                        i_jmp_reg,
    input  wire rv_isa_pkg::uintx_t    i_imm_b,
    input  wire rv_isa_pkg::uintx_t    i_imm_j,
    input  wire rv_isa_pkg::uintx_t    i_op1,
    input  wire rv_isa_pkg::uintx_t    i_op2,
    output rv_isa_pkg::uintx_t         o_alu_out,
    output logic                       o_branch_taken,
    output rv_isa_pkg::addr_t          o_branch_target,
    output logic                       o_stall
);

    rv_pipe_pkg::exe_state_t state;
    rv_isa_pkg::uintx_t      alu_result;
    rv_isa_pkg::uintx_t      saved_result;
    rv_isa_pkg::addr_t       target_sum;
    logic                    alu_branch_take;
    logic                    is_muldiv;
    logic                    start_md;

    muldiv_if md_bus ();

    alu alu_i (
        .i_alu_sel     (i_alu_sel),
        .i_br_sel      (i_br_sel),
        .i_sign_sel    (i_sign_sel),
        .i_op1         (i_op1),
        .i_op2         (i_op2),
        .o_result      (alu_result),
        .o_branch_take (alu_branch_take)
    );

    muldiv_unit muldiv_unit_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .md       (md_bus)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiply/divide issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_muldiv = i_alu_sel inside {rv_isa_pkg::ALU_MUL, rv_isa_pkg::ALU_MULH,
                                         rv_isa_pkg::ALU_MULHSU, rv_isa_pkg::ALU_MULHU,
                                         rv_isa_pkg::ALU_DIV, rv_isa_pkg::ALU_DIVU,
                                         rv_isa_pkg::ALU_REM, rv_isa_pkg::ALU_REMU};
    assign start_md  = i_valid && i_is_new && is_muldiv && (state == rv_pipe_pkg::IDLE);

    assign md_bus.req_valid = i_valid && !i_flush &&
                              (start_md || state == rv_pipe_pkg::WAIT_READY);
    assign md_bus.sel       = i_alu_sel;
    assign md_bus.op1       = i_op1;
    assign md_bus.op2       = i_op2;
    assign md_bus.kill      = (state != rv_pipe_pkg::IDLE) && (i_flush || !i_valid);

    assign o_stall = i_valid && (start_md ||
                                 state == rv_pipe_pkg::WAIT_READY ||
                                 (state == rv_pipe_pkg::WAIT_CALC && !md_bus.resp_valid));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= rv_pipe_pkg::IDLE;
        end else if (i_flush || !i_valid) begin
            state <= rv_pipe_pkg::IDLE;  // Engine is killed alongside.
        end else begin
            case (state)
                rv_pipe_pkg::IDLE: if (start_md) begin
                    state <= md_bus.req_ready ? rv_pipe_pkg::WAIT_CALC
                                              : rv_pipe_pkg::WAIT_READY;
                end
                rv_pipe_pkg::WAIT_READY: if (md_bus.req_ready) begin
                    state <= rv_pipe_pkg::WAIT_CALC;
                end
                rv_pipe_pkg::WAIT_CALC: if (md_bus.resp_valid) begin
                    state <= rv_pipe_pkg::IDLE;
                end
                default: state <= rv_pipe_pkg::IDLE;
            endcase
        end
    end

    // Held while the finished instruction stays in the stage.
    always_ff @(posedge clk) begin
        if (state == rv_pipe_pkg::WAIT_CALC && md_bus.resp_valid) begin
            saved_result <= md_bus.result;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result and branch outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign o_alu_out = (state == rv_pipe_pkg::WAIT_CALC) ? md_bus.result :
                       is_muldiv                         ? saved_result  : alu_result;

    assign o_branch_taken = i_valid && (i_jmp_pc || i_jmp_reg || alu_branch_take);

    always_comb begin
        if (i_jmp_pc) begin
            target_sum = i_pc + i_imm_j;  // JAL.
        end else if (i_jmp_reg) begin
            target_sum = i_op1 + i_op2;   // JALR.
        end else begin
            target_sum = i_pc + i_imm_b;
        end
    end

    assign o_branch_target = target_sum & ~rv_isa_pkg::addr_t'(1);

    // A bubble leaves no stall behind, only a new request raises it again.
    a_no_stall_invalid: assert property (@(posedge clk) disable iff (!i_arst_n)
        !i_valid |=> !o_stall || start_md);

    // Only the engine response or a kill ends the wait.
    a_calc_exit: assert property (@(posedge clk) disable iff (!i_arst_n)
        state == rv_pipe_pkg::WAIT_CALC && !md_bus.resp_valid && !md_bus.kill |=>
            state == rv_pipe_pkg::WAIT_CALC);

endmodule

`default_nettype wire

// File: logic/muldiv_if.sv
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if;

    logic                 req_valid;
    rv_isa_pkg::alu_sel_t sel;
    rv_isa_pkg::uintx_t   op1;
    rv_isa_pkg::uintx_t   op2;
    logic                 kill;        // Abort the operation in flight.
    logic                 req_ready;
    logic                 resp_valid;  // One-cycle pulse.
    rv_isa_pkg::uintx_t   result;

    modport master (
        output req_valid, sel, op1, op2, kill,
        input  req_ready, resp_valid, result
    );

    modport slave (
        input  req_valid, sel, op1, op2, kill,
        output req_ready, resp_valid, result
    );

endinterface

`default_nettype wire

// File: logic/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_defines.svh"

module muldiv_unit (
    input wire      clk,
    input wire      i_arst_n,
    muldiv_if.slave md
);

    rv_pipe_pkg::md_state_t state;
    rv_pipe_pkg::step_cnt_t step;
    rv_isa_pkg::alu_sel_t   sel_q;
    rv_isa_pkg::uintx_t     opb_q;       // Multiplicand or divisor magnitude.
    rv_isa_pkg::uintx_t     acc_hi;      // Product high or partial remainder.
    rv_isa_pkg::uintx_t     acc_lo;      // Multiplier/product low or quotient.
    logic                   neg_a_q;
    logic                   neg_b_q;

    logic                   accept;
    logic                   is_div;
    logic                   q_is_div;
    logic                   a_signed;
    logic                   b_signed;
    logic                   neg_a;
    logic                   neg_b;
    logic                   div_zero;
    logic                   div_ovf;
    rv_isa_pkg::uintx_t     mag_a;
    rv_isa_pkg::uintx_t     mag_b;
    logic [`RV_XLEN:0]      mul_sum;
    logic [`RV_XLEN:0]      div_shift;
    logic [`RV_XLEN:0]      div_diff;
    logic [2*`RV_XLEN-1:0]  prod;
    rv_isa_pkg::uintx_t     quot;
    rv_isa_pkg::uintx_t     rem;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign accept   = md.req_valid && md.req_ready && !md.kill;
    assign is_div   = md.sel inside {rv_isa_pkg::ALU_DIV, rv_isa_pkg::ALU_DIVU,
                                     rv_isa_pkg::ALU_REM, rv_isa_pkg::ALU_REMU};
    assign a_signed = md.sel inside {rv_isa_pkg::ALU_MULH, rv_isa_pkg::ALU_MULHSU,
                                     rv_isa_pkg::ALU_DIV, rv_isa_pkg::ALU_REM};
    assign b_signed = md.sel inside {rv_isa_pkg::ALU_MULH, rv_isa_pkg::ALU_DIV,
                                     rv_isa_pkg::ALU_REM};
    assign neg_a    = a_signed && md.op1[`RV_XLEN-1];
    assign neg_b    = b_signed && md.op2[`RV_XLEN-1];
    assign mag_a    = neg_a ? -md.op1 : md.op1;
    assign mag_b    = neg_b ? -md.op2 : md.op2;
    assign div_zero = is_div && (md.op2 == '0);
    assign div_ovf  = is_div && a_signed && (md.op1 == {1'b1, {(`RV_XLEN-1){1'b0}}})
                      && (md.op2 == '1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Engine FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= rv_pipe_pkg::MD_IDLE;
            step  <= '0;
        end else if (md.kill) begin
            state <= rv_pipe_pkg::MD_IDLE;
        end else begin
            case (state)
                rv_pipe_pkg::MD_IDLE: if (accept) begin
                    state <= (div_zero || div_ovf) ? rv_pipe_pkg::MD_DONE
                                                   : rv_pipe_pkg::MD_RUN;
                    step  <= '0;
                end
                rv_pipe_pkg::MD_RUN: begin
                    step <= step + 1'b1;
                    if (step == rv_pipe_pkg::step_cnt_t'(`RV_MD_STEPS - 1)) begin
                        state <= rv_pipe_pkg::MD_DONE;
                    end
                end
                default: state <= rv_pipe_pkg::MD_IDLE;  // DONE lasts one cycle.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign q_is_div  = sel_q inside {rv_isa_pkg::ALU_DIV, rv_isa_pkg::ALU_DIVU,
                                     rv_isa_pkg::ALU_REM, rv_isa_pkg::ALU_REMU};
    assign mul_sum   = {1'b0, acc_hi} + (acc_lo[0] ? {1'b0, opb_q} : '0);
    assign div_shift = {acc_hi, acc_lo[`RV_XLEN-1]};
    assign div_diff  = div_shift - {1'b0, opb_q};

    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q <= md.sel;
            opb_q <= mag_b;
            if (div_zero) begin
                acc_hi  <= md.op1;  // Remainder is the dividend.
                acc_lo  <= '1;
                neg_a_q <= 1'b0;
                neg_b_q <= 1'b0;
            end else if (div_ovf) begin
                acc_hi  <= '0;
                acc_lo  <= md.op1;  // Quotient is the dividend.
                neg_a_q <= 1'b0;
                neg_b_q <= 1'b0;
            end else begin
                acc_hi  <= '0;
                acc_lo  <= mag_a;
                neg_a_q <= neg_a;
                neg_b_q <= neg_b;
            end
        end else if (state == rv_pipe_pkg::MD_RUN) begin
            if (q_is_div) begin
                acc_hi <= div_diff[`RV_XLEN] ? div_shift[`RV_XLEN-1:0]
                                             : div_diff[`RV_XLEN-1:0];
                acc_lo <= {acc_lo[`RV_XLEN-2:0], !div_diff[`RV_XLEN]};
            end else begin
                {acc_hi, acc_lo} <= {mul_sum, acc_lo[`RV_XLEN-1:1]};
            end
        end
    end

    assign prod = (neg_a_q ^ neg_b_q) ? -{acc_hi, acc_lo} : {acc_hi, acc_lo};
    assign quot = (neg_a_q ^ neg_b_q) ? -acc_lo : acc_lo;
    assign rem  = neg_a_q ? -acc_hi : acc_hi;  // Follows the dividend sign.

    always_comb begin
        case (sel_q)
            rv_isa_pkg::ALU_MUL:    md.result = prod[`RV_XLEN-1:0];
            rv_isa_pkg::ALU_MULH,
            rv_isa_pkg::ALU_MULHSU,
            rv_isa_pkg::ALU_MULHU:  md.result = prod[2*`RV_XLEN-1:`RV_XLEN];
            rv_isa_pkg::ALU_DIV,
            rv_isa_pkg::ALU_DIVU:   md.result = quot;
            default:                md.result = rem;
        endcase
    end

    assign md.req_ready  = (state == rv_pipe_pkg::MD_IDLE);
    assign md.resp_valid = (state == rv_pipe_pkg::MD_DONE) && !md.kill;

    // Requester must hold its operands until they are taken.
    a_req_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        md.req_valid && !md.req_ready |=>
            !md.req_valid || ($stable(md.op1) && $stable(md.op2) && $stable(md.sel)));

    a_resp_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
        md.resp_valid |=> !md.resp_valid);

endmodule

`default_nettype wire

// File: logic/rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec (
    input  wire                        clk,
    input  wire                        i_arst_n,
    input  wire                        i_flush,
    input  wire                        i_valid,
    input  wire                        i_is_new,
    input  wire rv_isa_pkg::addr_t     i_pc,
    input  wire rv_isa_pkg::alu_sel_t  i_alu_sel,
    input  wire rv_isa_pkg::br_sel_t   i_br_sel,
    input  wire rv_isa_pkg::sign_sel_t i_sign_sel,
    input  wire                        i_jmp_pc,
    input  wire                        i_jmp_reg,
    input  wire rv_isa_pkg::uintx_t    i_imm_b,
    input  wire rv_isa_pkg::uintx_t    i_imm_j,
    input  wire rv_isa_pkg::uintx_t    i_op1,
    input  wire rv_isa_pkg::uintx_t    i_op2,
    output rv_isa_pkg::uintx_t         o_alu_out,
    output logic                       o_branch_taken,
    output rv_isa_pkg::addr_t          o_branch_target,
    output logic                       o_stall
);

    execute_stage execute_stage_i (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_flush         (i_flush),
        .i_valid         (i_valid),
        .i_is_new        (i_is_new),
        .i_pc            (i_pc),
        .i_alu_sel       (i_alu_sel),
        .i_br_sel        (i_br_sel),
        .i_sign_sel      (i_sign_sel),
        .i_jmp_pc        (i_jmp_pc),
        .i_jmp_reg       (i_jmp_reg),
        .i_imm_b         (i_imm_b),
        .i_imm_j         (i_imm_j),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .o_alu_out       (o_alu_out),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_stall         (o_stall)
    );

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

`include "rv_exec_defines.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0] uintx_t;  // Operand and result word.
    typedef logic [`RV_XLEN-1:0] addr_t;   // Instruction address.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute operation select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_COPY1,   // Pass op1 through.
        ALU_MUL,     // Iterative unit from here on.
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU,
        ALU_DIV,
        ALU_DIVU,
        ALU_REM,
        ALU_REMU
    } alu_sel_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } br_sel_t;

    typedef enum logic {
        OP_UNSIGNED,
        OP_SIGNED
    } sign_sel_t;

endpackage

`default_nettype wire

// File: logic/rv_pipe_pkg.sv
`default_nettype none

`include "rv_exec_defines.svh"

package rv_pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage and engine FSMs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        IDLE,
        WAIT_READY,  // Request pending, engine busy.
        WAIT_CALC    // Engine running.
    } exe_state_t;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_RUN,
        MD_DONE      // Response cycle.
    } md_state_t;

    // Iteration counter of the multiply/divide engine.
    typedef logic [$clog2(`RV_MD_STEPS + 1)-1:0] step_cnt_t;

endpackage

`default_nettype wire

// File: rv_exec.f
+incdir+include
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/muldiv_if.sv
logic/alu.sv
logic/muldiv_unit.sv
logic/execute_stage.sv
logic/rv_exec.sv
verif/rv_exec_ref_pkg.sv
verif/rv_exec_tb.sv

// File: verif/rv_exec_ref_pkg.sv
`default_nettype none

`include "rv_exec_defines.svh"

package rv_exec_ref_pkg;

    typedef logic [2*`RV_XLEN-1:0] dword_t;

    function automatic logic is_muldiv(rv_isa_pkg::alu_sel_t sel);
        return sel inside {rv_isa_pkg::ALU_MUL, rv_isa_pkg::ALU_MULH, rv_isa_pkg::ALU_MULHSU,
                           rv_isa_pkg::ALU_MULHU, rv_isa_pkg::ALU_DIV, rv_isa_pkg::ALU_DIVU,
                           rv_isa_pkg::ALU_REM, rv_isa_pkg::ALU_REMU};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Base integer operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic rv_isa_pkg::uintx_t alu_expect(rv_isa_pkg::alu_sel_t sel,
                                                      rv_isa_pkg::uintx_t a,
                                                      rv_isa_pkg::uintx_t b);
        int unsigned sh;
        sh = b % `RV_XLEN;  // Shift amount is the low bits of op2.
        case (sel)
            rv_isa_pkg::ALU_ADD:   return a + b;
            rv_isa_pkg::ALU_SUB:   return a - b;
            rv_isa_pkg::ALU_AND:   return a & b;
            rv_isa_pkg::ALU_OR:    return a | b;
            rv_isa_pkg::ALU_XOR:   return a ^ b;
            rv_isa_pkg::ALU_SLL:   return a << sh;
            rv_isa_pkg::ALU_SRL:   return a >> sh;
            rv_isa_pkg::ALU_SRA:   return rv_isa_pkg::uintx_t'($signed(a) >>> sh);
            rv_isa_pkg::ALU_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
            rv_isa_pkg::ALU_SLTU:  return (a < b) ? 1 : 0;
            rv_isa_pkg::ALU_COPY1: return a;
            default:               return '0;
        endcase
    endfunction

    function automatic logic branch_cond(rv_isa_pkg::br_sel_t br,
                                         rv_isa_pkg::uintx_t a, rv_isa_pkg::uintx_t b);
        case (br)
            rv_isa_pkg::BR_BEQ:  return a == b;
            rv_isa_pkg::BR_BNE:  return a != b;
            rv_isa_pkg::BR_BLT:  return $signed(a) < $signed(b);
            rv_isa_pkg::BR_BGE:  return $signed(a) >= $signed(b);
            rv_isa_pkg::BR_BLTU: return a < b;
            rv_isa_pkg::BR_BGEU: return a >= b;
            default:             return 1'b0;
        endcase
    endfunction

    function automatic rv_isa_pkg::addr_t target_expect(logic jmp_pc, logic jmp_reg,
                                                        rv_isa_pkg::addr_t pc,
                                                        rv_isa_pkg::uintx_t imm_j,
                                                        rv_isa_pkg::uintx_t imm_b,
                                                        rv_isa_pkg::uintx_t a,
                                                        rv_isa_pkg::uintx_t b);
        rv_isa_pkg::addr_t sum;
        sum = jmp_pc ? pc + imm_j : jmp_reg ? a + b : pc + imm_b;
        return {sum[`RV_XLEN-1:1], 1'b0};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiply and divide
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic rv_isa_pkg::uintx_t md_expect(rv_isa_pkg::alu_sel_t sel,
                                                     rv_isa_pkg::uintx_t a,
                                                     rv_isa_pkg::uintx_t b);
        logic signed [`RV_XLEN-1:0] sa;
        logic signed [`RV_XLEN-1:0] sb;
        dword_t                     ea;
        dword_t                     eb;
        dword_t                     prod;
        logic                       ovf;
        sa   = a;
        sb   = b;
        ea   = (sel inside {rv_isa_pkg::ALU_MULH, rv_isa_pkg::ALU_MULHSU}) ?
               {{`RV_XLEN{a[`RV_XLEN-1]}}, a} : {{`RV_XLEN{1'b0}}, a};
        eb   = (sel == rv_isa_pkg::ALU_MULH) ?
               {{`RV_XLEN{b[`RV_XLEN-1]}}, b} : {{`RV_XLEN{1'b0}}, b};
        prod = ea * eb;  // Low 64 bits are exact for any sign mix.
        ovf  = (a == {1'b1, {(`RV_XLEN-1){1'b0}}}) && (b == '1);
        case (sel)
            rv_isa_pkg::ALU_MUL:  return prod[`RV_XLEN-1:0];
            rv_isa_pkg::ALU_DIV:  return (b == '0) ? '1 : ovf ? a : rv_isa_pkg::uintx_t'(sa / sb);
            rv_isa_pkg::ALU_DIVU: return (b == '0) ? '1 : a / b;
            rv_isa_pkg::ALU_REM:  return (b == '0) ? a : ovf ? '0 : rv_isa_pkg::uintx_t'(sa % sb);
            rv_isa_pkg::ALU_REMU: return (b == '0) ? a : a % b;
            default:              return prod[2*`RV_XLEN-1:`RV_XLEN];
        endcase
    endfunction

endpackage

`default_nettype wire

// File: verif/rv_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_defines.svh"

module rv_exec_tb;

    localparam int N_RAND     = 40;
    localparam int N_MD       = 6;   // Per multiply/divide operation.
    localparam int NUM_OPS    = 2 * N_RAND + 8 * N_MD + 6;
    localparam int CLK_PERIOD = 20;

    logic                  clk;
    logic                  i_arst_n;
    logic                  i_flush;
    logic                  i_valid;
    logic                  i_is_new;
    rv_isa_pkg::addr_t     i_pc;
    rv_isa_pkg::alu_sel_t  i_alu_sel;
    rv_isa_pkg::br_sel_t   i_br_sel;
    rv_isa_pkg::sign_sel_t i_sign_sel;
    logic                  i_jmp_pc;
    logic                  i_jmp_reg;
    rv_isa_pkg::uintx_t    i_imm_b;
    rv_isa_pkg::uintx_t    i_imm_j;
    rv_isa_pkg::uintx_t    i_op1;
    rv_isa_pkg::uintx_t    i_op2;
    rv_isa_pkg::uintx_t    o_alu_out;
    logic                  o_branch_taken;
    rv_isa_pkg::addr_t     o_branch_target;
    logic                  o_stall;

    rv_isa_pkg::uintx_t    exp_alu;
    rv_isa_pkg::uintx_t    exp_md;
    rv_isa_pkg::addr_t     exp_target;
    logic                  exp_taken;
    logic                  op_is_md;

    int errors;
    int errors_at_start;
    int tests_run;
    int tests_failed;
    rv_isa_pkg::uintx_t edge_vals [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
                                           32'hffff_ffff};

    rv_exec rv_exec_i (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_flush         (i_flush),
        .i_valid         (i_valid),
        .i_is_new        (i_is_new),
        .i_pc            (i_pc),
        .i_alu_sel       (i_alu_sel),
        .i_br_sel        (i_br_sel),
        .i_sign_sel      (i_sign_sel),
        .i_jmp_pc        (i_jmp_pc),
        .i_jmp_reg       (i_jmp_reg),
        .i_imm_b         (i_imm_b),
        .i_imm_j         (i_imm_j),
        .i_op1           (i_op1),
        .i_op2           (i_op2),
        .o_alu_out       (o_alu_out),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_stall         (o_stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always_comb begin
        op_is_md   = rv_exec_ref_pkg::is_muldiv(i_alu_sel);
        exp_alu    = rv_exec_ref_pkg::alu_expect(i_alu_sel, i_op1, i_op2);
        exp_md     = rv_exec_ref_pkg::md_expect(i_alu_sel, i_op1, i_op2);
        exp_taken  = i_valid && (i_jmp_pc || i_jmp_reg ||
                                 rv_exec_ref_pkg::branch_cond(i_br_sel, i_op1, i_op2));
        exp_target = rv_exec_ref_pkg::target_expect(i_jmp_pc, i_jmp_reg, i_pc, i_imm_j,
                                                    i_imm_b, i_op1, i_op2);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string name, input rv_isa_pkg::uintx_t got,
                                   input rv_isa_pkg::uintx_t exp);
        errors++;
        $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = errors - errors_at_start;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("Test %-8s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
        errors_at_start = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_alu_value: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && !op_is_md |-> o_alu_out == exp_alu)
        else report_mismatch("o_alu_out", $sampled(o_alu_out), $sampled(exp_alu));

    a_alu_no_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && !op_is_md |-> !o_stall)
        else report_fail("o_stall was high for a single-cycle operation");

    a_taken: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_branch_taken == exp_taken)
        else report_mismatch("o_branch_taken", $sampled(o_branch_taken), $sampled(exp_taken));

    a_target: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid |-> o_branch_target == exp_target)
        else report_mismatch("o_branch_target", $sampled(o_branch_target),
                             $sampled(exp_target));

    a_md_start: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && i_is_new && op_is_md && !i_flush |-> o_stall)
        else report_fail("o_stall did not rise on a new multiply/divide");

    // Covers the completion cycle and the held cycles after it.
    a_md_result: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && op_is_md && !o_stall |-> o_alu_out == exp_md)
        else report_mismatch("o_alu_out", $sampled(o_alu_out), $sampled(exp_md));

    a_md_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && !i_is_new && op_is_md && $past(i_valid && !o_stall) |-> !o_stall)
        else report_fail("o_stall rose again while a finished instruction was held");

    a_flush_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid && i_flush |=> !o_stall || (i_valid && i_is_new && op_is_md))
        else report_fail("o_stall stayed high in the cycle after a flush");

    a_idle_no_stall: assert property (@(posedge clk) disable iff (!i_arst_n)
        !i_valid |-> !o_stall)
        else report_fail("o_stall was high with no valid instruction");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic rv_isa_pkg::uintx_t rand_word();
        return ($urandom_range(3, 0) == 0) ? edge_vals[$urandom_range(4, 0)] : $urandom();
    endfunction

    task automatic issue(input rv_isa_pkg::alu_sel_t sel, input rv_isa_pkg::uintx_t a,
                         input rv_isa_pkg::uintx_t b);
        @(posedge clk);
        #2;
        i_valid   = 1'b1;
        i_is_new  = 1'b1;
        i_flush   = 1'b0;
        i_alu_sel = sel;
        i_op1     = a;
        i_op2     = b;
    endtask

    task automatic bubble();
        @(posedge clk);
        #2;
        i_valid   = 1'b0;
        i_is_new  = 1'b0;
        i_flush   = 1'b0;
        i_jmp_pc  = 1'b0;
        i_jmp_reg = 1'b0;
        i_br_sel  = rv_isa_pkg::BR_NONE;
    endtask

    // Waits for the stall to fall, then holds the instruction for a few cycles.
    task automatic run_muldiv(input rv_isa_pkg::alu_sel_t sel, input rv_isa_pkg::uintx_t a,
                              input rv_isa_pkg::uintx_t b, input int hold);
        issue(sel, a, b);
        #1;
        while (o_stall) begin
            @(posedge clk);
            #2 i_is_new = 1'b0;
            #1;
        end
        repeat (hold) begin
            @(posedge clk);
            #2 i_is_new = 1'b0;
        end
        bubble();
    endtask

    initial begin
        #(NUM_OPS * (`RV_MD_STEPS + 4) * CLK_PERIOD + 50 * CLK_PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    initial begin
        rv_isa_pkg::uintx_t   a;
        rv_isa_pkg::uintx_t   b;
        rv_isa_pkg::alu_sel_t sel;
        void'($urandom(32'h8ce9_9882));
        clk        = 1'b0;
        i_arst_n   = 1'b0;
        i_flush    = 1'b0;
        i_valid    = 1'b0;
        i_is_new   = 1'b0;
        i_pc       = '0;
        i_alu_sel  = rv_isa_pkg::ALU_ADD;
        i_br_sel   = rv_isa_pkg::BR_NONE;
        i_sign_sel = rv_isa_pkg::OP_UNSIGNED;
        i_jmp_pc   = 1'b0;
        i_jmp_reg  = 1'b0;
        i_imm_b    = '0;
        i_imm_j    = '0;
        i_op1      = '0;
        i_op2      = '0;
        errors     = 0;
        tests_run  = 0;
        tests_failed    = 0;
        errors_at_start = 0;
        repeat (3) @(posedge clk);
        #2 i_arst_n = 1'b1;

        for (int n = 0; n < N_RAND; n++) begin
            issue(rv_isa_pkg::alu_sel_t'($urandom_range(10, 0)), rand_word(), rand_word());
        end
        bubble();
        end_test("alu");

        for (int n = 0; n < N_RAND; n++) begin
            a = rand_word();
            issue(rv_isa_pkg::ALU_ADD, a, ($urandom_range(3, 0) == 0) ? a : rand_word());
            i_br_sel   = rv_isa_pkg::br_sel_t'($urandom_range(6, 0));
            i_sign_sel = rv_isa_pkg::sign_sel_t'($urandom_range(1, 0));
            i_jmp_pc   = ($urandom_range(7, 0) == 0);
            i_jmp_reg  = !i_jmp_pc && ($urandom_range(7, 0) == 0);
            i_pc       = $urandom();
            i_imm_b    = $urandom();
            i_imm_j    = $urandom();
        end
        bubble();
        end_test("branch");

        for (int s = 0; s < 4; s++) begin
            sel = rv_isa_pkg::alu_sel_t'(int'(rv_isa_pkg::ALU_MUL) + s);
            for (int n = 0; n < N_MD; n++) begin
                a = (n < 3) ? edge_vals[(n + 3) % 5] : rand_word();
                b = (n < 3) ? edge_vals[(n + 4) % 5] : rand_word();
                run_muldiv(sel, a, b, 0);
            end
        end
        end_test("mul");

        for (int s = 0; s < 4; s++) begin
            sel = rv_isa_pkg::alu_sel_t'(int'(rv_isa_pkg::ALU_DIV) + s);
            for (int n = 0; n < N_MD; n++) begin
                a = (n == 1) ? edge_vals[3] : rand_word();
                b = (n == 0) ? '0 : (n == 1) ? edge_vals[4] :
                    (n == 2) ? rv_isa_pkg::uintx_t'($urandom_range(9, 1)) : rand_word();
                run_muldiv(sel, a, b, 2);
            end
        end
        end_test("div");

        // A single-cycle op right after each flush shows whether the stage left WAIT_CALC.
        issue(rv_isa_pkg::ALU_MUL, rand_word(), rand_word());
        repeat (4) begin
            @(posedge clk);
            #2 i_is_new = 1'b0;
        end
        i_flush = 1'b1;  // Engine is mid-run here.
        issue(rv_isa_pkg::ALU_ADD, rand_word(), rand_word());
        run_muldiv(rv_isa_pkg::ALU_MULHU, rand_word(), rand_word(), 1);
        issue(rv_isa_pkg::ALU_DIV, rand_word(), rand_word());
        @(posedge clk);
        #2;
        i_is_new = 1'b0;
        i_flush  = 1'b1;
        issue(rv_isa_pkg::ALU_ADD, rand_word(), rand_word());
        run_muldiv(rv_isa_pkg::ALU_REM, rand_word(), rand_word(), 1);
        end_test("flush");

        $display("Tests run: %0d, failing: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
